/* project.f */
+incdir+hw
+incdir+tests
hw/dvbs2_frm_pkg.sv
hw/frame_len_rom.sv
hw/frame_phase_ctrl.sv
hw/ts_pkt_framer.sv
hw/dvbs2_frame_timing_top.sv
tests/tb_dvbs2_frame_timing.sv

/* Makefile */
# Verilator build and run of the frame timing testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_dvbs2_frame_timing
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= TB PASSED

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_frame_model.svh */
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

//////////////////////////////
// mode tables
//////////////////////////////

// bch payload bytes, kbch bits over 8
// zero for a rate past the end of the frame size's list
function automatic int kbch_ref(input logic short_frm, input logic [3:0] rate);
	int normal_bits [11] = '{16008, 21408, 25728, 32208, 38688, 43040,
		48408, 51648, 53840, 57472, 58192};
	int short_bits [10] = '{3072, 5232, 6312, 7032, 9552, 10632,
		11712, 12432, 13152, 14232};
	if (!short_frm && rate <= 4'd10)
		return normal_bits[rate] / 8;
	if (short_frm && rate <= 4'd9)
		return short_bits[rate] / 8;
	return 0;
endfunction

// ts bytes, payload less the 10-byte bb header
function automatic int ts_ref(input int kbch);
	return (kbch == 0) ? 0 : kbch - 10;
endfunction

// 90-symbol slots plus one header slot
// a 36-symbol pilot block after every 16 slots
function automatic int pl_len_ref(input logic short_frm, input logic pilot,
	input logic [1:0] mod);
	int bits_per_sym;
	int slots;
	int len;
	bits_per_sym = int'(mod) + 2;
	slots = (short_frm ? 16200 : 64800) / bits_per_sym / 90;
	len = 90 * (slots + 1);
	if (pilot)
		len = len + 36 * ((slots - 1) / 16);
	return len;
endfunction

//////////////////////////////
// phase, framer and lfsr
//////////////////////////////

// one symbol, returns 1 on a wrap
// overshoot carried, new length taken at the wrap
function automatic logic phase_step(inout int phase, inout int cur_len, input int next_len);
	int cand;
	cand = phase + 1;
	if (cand >= cur_len) begin
		phase = cand - cur_len;
		cur_len = next_len;
		return 1'b1;
	end
	phase = cand;
	return 1'b0;
endfunction

// window covers phase 1..win_len
function automatic logic in_window(input int phase, input int win_len);
	return (phase != 0) && (phase <= win_len);
endfunction

// packet position after one byte
function automatic int pkt_next(input int pos);
	return (pos == `TS_PKT_LEN - 1) ? 0 : pos + 1;
endfunction

// fibonacci, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

/* tests/tb_dvbs2_frame_timing.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dvbs2_frm_cfg.svh"

module tb_dvbs2_frame_timing;

	import dvbs2_frm_pkg::*;

	`include "tb_frame_model.svh"

	localparam int CLK_NS = 10;
	// longest plframe, normal qpsk with pilots
	localparam int MAX_FRAME = 33282;
	// 3 wraps for windows, 2 per sweep step, 2 per invalid step
	localparam int WRAP_WAITS = 3 + 2 * 7 + 2 * 2;
	// sym_en near half rate, four cycles per symbol is plenty
	localparam int WDOG_NS = (WRAP_WAITS * MAX_FRAME * 4 + 1000) * CLK_NS;

	logic        sys_clk;
	logic        glb_rst_n;
	frame_mode_t frame_mode;
	logic        pilot_mode;
	mod_mode_t   mod_mode;
	ldpc_rate_t  ldpc_rate;
	logic        sym_en;
	logic        byte_en;
	logic [7:0]  byte_in;
	logic        bb_frame_vld;
	logic        ts_rd_vld;
	logic [7:0]  ts_data;
	logic        ts_valid;
	logic        ts_head;

	logic [31:0] lfsr_state;
	string       test_name;
	// windows must stay dark, rate is invalid
	logic        expect_dark;
	int          val_err;
	int          other_err;

	// reference state
	int          m_phase;
	int          m_cur_len;
	int          m_kbch;
	int          m_ts;
	int          m_pl;
	int          m_pkt_pos;
	int          wrap_cnt;
	logic        m_bb;
	logic        m_tsrd;
	logic [7:0]  m_data;
	logic        m_valid;
	logic        m_head;

	dvbs2_frame_timing_top UUT (
		.sys_clk      (sys_clk),
		.glb_rst_n    (glb_rst_n),
		.frame_mode   (frame_mode),
		.pilot_mode   (pilot_mode),
		.mod_mode     (mod_mode),
		.ldpc_rate    (ldpc_rate),
		.sym_en       (sym_en),
		.byte_en      (byte_en),
		.byte_in      (byte_in),
		.bb_frame_vld (bb_frame_vld),
		.ts_rd_vld    (ts_rd_vld),
		.ts_data      (ts_data),
		.ts_valid     (ts_valid),
		.ts_head      (ts_head)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_NS / 2) sys_clk = ~sys_clk;
	end

	//////////////////////////////
	// random strobes
	//////////////////////////////

	function automatic logic next_rand_bit();
		lfsr_state = lfsr_next(lfsr_state);
		return lfsr_state[0];
	endfunction

	function automatic logic [7:0] next_rand_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++)
			b = {b[6:0], next_rand_bit()};
		return b;
	endfunction

	// strobes and data 1 ns past each rising edge
	initial begin
		forever begin
			@(posedge sys_clk);
			#1;
			sym_en = next_rand_bit();
			byte_en = next_rand_bit();
			byte_in = next_rand_byte();
		end
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	// steps from the inputs seen at each edge
	always @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			m_phase = 0;
			m_cur_len = `FRM_RESET_LEN;
			m_kbch = 0;
			m_ts = 0;
			m_pl = 0;
			m_pkt_pos = 0;
			wrap_cnt = 0;
			m_bb = 1'b0;
			m_tsrd = 1'b0;
			m_data = '0;
			m_valid = 1'b0;
			m_head = 1'b0;
		end else begin
			// flags from old phase and old table
			m_bb = in_window(m_phase, m_kbch);
			m_tsrd = in_window(m_phase, m_ts);
			if (sym_en) begin
				if (phase_step(m_phase, m_cur_len, m_pl))
					wrap_cnt++;
			end
			m_kbch = kbch_ref(frame_mode, ldpc_rate);
			m_ts = ts_ref(m_kbch);
			m_pl = pl_len_ref(frame_mode, pilot_mode, mod_mode);
			if (byte_en) begin
				m_data = byte_in;
				m_valid = 1'b1;
				m_head = (m_pkt_pos == 0);
				m_pkt_pos = pkt_next(m_pkt_pos);
			end else begin
				m_valid = 1'b0;
				m_head = 1'b0;
			end
		end
	end

	//////////////////////////////
	// compare
	//////////////////////////////

	task automatic check_val(input string sig, input int exp, input int act);
		assert (act == exp) else begin
			$display("[FAIL] %s %s: expected %0h actual %0h", test_name, sig, exp, act);
			val_err++;
		end
	endtask

	// outputs settled at the falling edge
	always @(negedge sys_clk) begin
		check_val("bb_frame_vld", int'(m_bb), int'(bb_frame_vld));
		check_val("ts_rd_vld", int'(m_tsrd), int'(ts_rd_vld));
		check_val("ts_data", int'(m_data), int'(ts_data));
		check_val("ts_valid", int'(m_valid), int'(ts_valid));
		check_val("ts_head", int'(m_head), int'(ts_head));
		if (expect_dark) begin
			assert (!bb_frame_vld && !ts_rd_vld) else begin
				$display("[FAIL] %s windows: expected 00 actual %b%b",
					test_name, bb_frame_vld, ts_rd_vld);
				val_err++;
			end
		end
	end

	//////////////////////////////
	// sequencing
	//////////////////////////////

	task automatic set_mode(input frame_mode_t fm, input logic pil, input mod_mode_t mm,
		input ldpc_rate_t rate);
		@(posedge sys_clk);
		#1;
		frame_mode = fm;
		pilot_mode = pil;
		mod_mode = mm;
		ldpc_rate = rate;
	endtask

	task automatic wait_wraps(input int n);
		int target;
		target = wrap_cnt + n;
		while (wrap_cnt < target) begin
			@(posedge sys_clk);
			#1;
		end
	endtask

	// table then flag register, two edges until dark
	task automatic run_dark();
		repeat (2) @(posedge sys_clk);
		#1;
		expect_dark = 1'b1;
		wait_wraps(2);
		expect_dark = 1'b0;
	endtask

	task automatic report_and_finish();
		$display("error counts: %0d value mismatches, %0d other", val_err, other_err);
		if (val_err == 0 && other_err == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	endtask

	initial begin
		glb_rst_n = 1'b0;
		frame_mode = FRM_NORMAL;
		pilot_mode = 1'b0;
		mod_mode = MOD_QPSK;
		ldpc_rate = 4'd6;
		sym_en = 1'b0;
		byte_en = 1'b0;
		byte_in = '0;
		lfsr_state = 32'h4d4e_53e9;
		test_name = "reset";
		expect_dark = 1'b0;
		val_err = 0;
		other_err = 0;
		repeat (4) @(posedge sys_clk);
		#1;
		glb_rst_n = 1'b1;
		// reset frame, then two full normal qpsk frames
		test_name = "frame_windows";
		wait_wraps(3);
		// length change only lands at the next wrap
		test_name = "mode_sweep";
		set_mode(FRM_NORMAL, 1'b0, MOD_8PSK, 4'd3);
		wait_wraps(2);
		set_mode(FRM_NORMAL, 1'b1, MOD_16APSK, 4'd8);
		wait_wraps(2);
		set_mode(FRM_NORMAL, 1'b1, MOD_32APSK, 4'd10);
		wait_wraps(2);
		set_mode(FRM_SHORT, 1'b0, MOD_QPSK, 4'd0);
		wait_wraps(2);
		set_mode(FRM_SHORT, 1'b1, MOD_8PSK, 4'd5);
		wait_wraps(2);
		set_mode(FRM_SHORT, 1'b0, MOD_16APSK, 4'd9);
		wait_wraps(2);
		set_mode(FRM_SHORT, 1'b1, MOD_32APSK, 4'd2);
		wait_wraps(2);
		test_name = "invalid_rate";
		set_mode(FRM_NORMAL, 1'b0, MOD_QPSK, 4'd11);
		run_dark();
		set_mode(FRM_SHORT, 1'b1, MOD_8PSK, 4'd10);
		run_dark();
		report_and_finish();
	end

	// bound on the whole run from the wrap budget
	initial begin
		#(WDOG_NS);
		$display("timeout: frame wraps did not complete within %0d ns", WDOG_NS);
		other_err++;
		report_and_finish();
	end

endmodule

`default_nettype wire

/* hw/dvbs2_frame_timing_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dvbs2_frame_timing_top (
	input  logic                      sys_clk,
	input  logic                      glb_rst_n,
	input  dvbs2_frm_pkg::frame_mode_t frame_mode,
	input  logic                      pilot_mode,
	input  dvbs2_frm_pkg::mod_mode_t   mod_mode,
	input  dvbs2_frm_pkg::ldpc_rate_t  ldpc_rate,
	input  logic                      sym_en,
	input  logic                      byte_en,
	input  logic [7:0]                byte_in,
	output logic                      bb_frame_vld,
	output logic                      ts_rd_vld,
	output logic [7:0]                ts_data,
	output logic                      ts_valid,
	output logic                      ts_head
);

	import dvbs2_frm_pkg::*;

	// registered table outputs
	frm_cnt_t kbch_bytes;
	frm_cnt_t ts_bytes;
	frm_cnt_t pl_len;

	//////////////////////////////
	// mode tables
	//////////////////////////////

	frame_len_rom u_frame_len_rom (
		.sys_clk    (sys_clk),
		.glb_rst_n  (glb_rst_n),
		.frame_mode (frame_mode),
		.ldpc_rate  (ldpc_rate),
		.pilot_mode (pilot_mode),
		.mod_mode   (mod_mode),
		.kbch_bytes (kbch_bytes),
		.ts_bytes   (ts_bytes),
		.pl_len     (pl_len)
	);

	// frame phase and windows, stepped by sym_en
	frame_phase_ctrl u_frame_phase_ctrl (
		.sys_clk      (sys_clk),
		.glb_rst_n    (glb_rst_n),
		.sym_en       (sym_en),
		.kbch_bytes   (kbch_bytes),
		.ts_bytes     (ts_bytes),
		.pl_len       (pl_len),
		.bb_frame_vld (bb_frame_vld),
		.ts_rd_vld    (ts_rd_vld)
	);

	//////////////////////////////
	// ts input side
	//////////////////////////////

	ts_pkt_framer u_ts_pkt_framer (
		.sys_clk   (sys_clk),
		.glb_rst_n (glb_rst_n),
		.byte_en   (byte_en),
		.byte_in   (byte_in),
		.ts_data   (ts_data),
		.ts_valid  (ts_valid),
		.ts_head   (ts_head)
	);

endmodule

`default_nettype wire

/* hw/ts_pkt_framer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dvbs2_frm_cfg.svh"

module ts_pkt_framer (
	input  logic       sys_clk,
	input  logic       glb_rst_n,
	input  logic       byte_en,
	input  logic [7:0] byte_in,
	output logic [7:0] ts_data,
	output logic       ts_valid,
	output logic       ts_head
);

	import dvbs2_frm_pkg::*;

	// last packet position before wrap
	localparam ts_phase_t PKT_LAST = ts_phase_t'(`TS_PKT_LEN - 1);

	// byte position of the next strobe
	ts_phase_t pkt_phase;

	//////////////////////////////
	// packet phase counter
	//////////////////////////////

	// counts strobes mod 188
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			pkt_phase <= '0;
		end else if (byte_en) begin
			if (pkt_phase == PKT_LAST)
				pkt_phase <= '0;
			else
				pkt_phase <= pkt_phase + ts_phase_t'(1);
		end
	end

	//////////////////////////////
	// output register
	//////////////////////////////

	// one cycle from strobe to output
	// head marks the sync byte position
	// data holds between strobes
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			ts_data  <= '0;
			ts_valid <= 1'b0;
			ts_head  <= 1'b0;
		end else if (byte_en) begin
			ts_data  <= byte_in;
			ts_valid <= 1'b1;
			ts_head  <= (pkt_phase == '0);
		end else begin
			ts_valid <= 1'b0;
			ts_head  <= 1'b0;
		end
	end

	// a head is always a real byte
	a_head_valid: assert property (@(posedge sys_clk) disable iff (!glb_rst_n)
		ts_head |-> ts_valid);

endmodule

`default_nettype wire

/* hw/frame_phase_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dvbs2_frm_cfg.svh"

module frame_phase_ctrl (
	input  logic                   sys_clk,
	input  logic                   glb_rst_n,
	input  logic                   sym_en,
	input  dvbs2_frm_pkg::frm_cnt_t kbch_bytes,
	input  dvbs2_frm_pkg::frm_cnt_t ts_bytes,
	input  dvbs2_frm_pkg::frm_cnt_t pl_len,
	output logic                   bb_frame_vld,
	output logic                   ts_rd_vld
);

	import dvbs2_frm_pkg::*;

	// position inside the current plframe
	frm_cnt_t phase;
	// frame length in force, latched at each wrap
	frm_cnt_t cur_len;
	// phase after one more symbol
	frm_cnt_t cand;

	//////////////////////////////
	// frame phase accumulator
	//////////////////////////////

	// phase < cur_len so +1 never overflows the count width
	always_comb begin
		cand = phase + frm_cnt_t'(1);
	end

	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			phase   <= '0;
			cur_len <= frm_cnt_t'(`FRM_RESET_LEN);
		end else if (sym_en) begin
			if (cand >= cur_len) begin
				// frame boundary
				// keep overshoot, pick up new length here only
				phase   <= cand - cur_len;
				cur_len <= pl_len;
			end else begin
				phase <= cand;
			end
		end
	end

	//////////////////////////////
	// window flags
	//////////////////////////////

	// scrambler window over phase 1..kbch
	// ts read window over phase 1..ts_bytes
	// both lag the phase by one cycle
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			bb_frame_vld <= 1'b0;
			ts_rd_vld    <= 1'b0;
		end else begin
			bb_frame_vld <= (phase != '0) && (phase <= kbch_bytes);
			ts_rd_vld    <= (phase != '0) && (phase <= ts_bytes);
		end
	end

	// needs a non-zero length from the table at every wrap
	a_phase_in_frame: assert property (@(posedge sys_clk) disable iff (!glb_rst_n)
		phase < cur_len);

	// ts window nests inside the bb window, table keeps ts below kbch
	a_ts_in_bb: assert property (@(posedge sys_clk) disable iff (!glb_rst_n)
		ts_rd_vld |-> bb_frame_vld);

endmodule

`default_nettype wire

/* hw/frame_len_rom.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dvbs2_frm_cfg.svh"

module frame_len_rom (
	input  logic                      sys_clk,
	input  logic                      glb_rst_n,
	input  dvbs2_frm_pkg::frame_mode_t frame_mode,
	input  dvbs2_frm_pkg::ldpc_rate_t  ldpc_rate,
	input  logic                      pilot_mode,
	input  dvbs2_frm_pkg::mod_mode_t   mod_mode,
	output dvbs2_frm_pkg::frm_cnt_t    kbch_bytes,
	output dvbs2_frm_pkg::frm_cnt_t    ts_bytes,
	output dvbs2_frm_pkg::frm_cnt_t    pl_len
);

	import dvbs2_frm_pkg::*;

	// baseband header length in bytes
	localparam frm_cnt_t BB_HDR_BYTES = frm_cnt_t'(10);

	frm_cnt_t kbch_nxt;
	frm_cnt_t ts_nxt;
	frm_cnt_t pl_nxt;

	//////////////////////////////
	// bch payload and ts byte table
	//////////////////////////////

	// kbch/8 per frame size and rate
	// second column is kbch less the bb header
	always_comb begin
		case ({frame_mode, ldpc_rate})
			{FRM_NORMAL, 4'd0}:  {kbch_nxt, ts_nxt} = {frm_cnt_t'(2001), frm_cnt_t'(1991)};
			{FRM_NORMAL, 4'd1}:  {kbch_nxt, ts_nxt} = {frm_cnt_t'(2676), frm_cnt_t'(2666)};
			{FRM_NORMAL, 4'd2}:  {kbch_nxt, ts_nxt} = {frm_cnt_t'(3216), frm_cnt_t'(3206)};
			{FRM_NORMAL, 4'd3}:  {kbch_nxt, ts_nxt} = {frm_cnt_t'(4026), frm_cnt_t'(4016)};
			{FRM_NORMAL, 4'd4}:  {kbch_nxt, ts_nxt} = {frm_cnt_t'(4836), frm_cnt_t'(4826)};
			{FRM_NORMAL, 4'd5}:  {kbch_nxt, ts_nxt} = {frm_cnt_t'(5380), frm_cnt_t'(5370)};
			{FRM_NORMAL, 4'd6}:  {kbch_nxt, ts_nxt} = {frm_cnt_t'(6051), frm_cnt_t'(6041)};
			{FRM_NORMAL, 4'd7}:  {kbch_nxt, ts_nxt} = {frm_cnt_t'(6456), frm_cnt_t'(6446)};
			{FRM_NORMAL, 4'd8}:  {kbch_nxt, ts_nxt} = {frm_cnt_t'(6730), frm_cnt_t'(6720)};
			{FRM_NORMAL, 4'd9}:  {kbch_nxt, ts_nxt} = {frm_cnt_t'(7184), frm_cnt_t'(7174)};
			{FRM_NORMAL, 4'd10}: {kbch_nxt, ts_nxt} = {frm_cnt_t'(7274), frm_cnt_t'(7264)};
			// short frames
			{FRM_SHORT, 4'd0}:   {kbch_nxt, ts_nxt} = {frm_cnt_t'(384), frm_cnt_t'(374)};
			{FRM_SHORT, 4'd1}:   {kbch_nxt, ts_nxt} = {frm_cnt_t'(654), frm_cnt_t'(644)};
			{FRM_SHORT, 4'd2}:   {kbch_nxt, ts_nxt} = {frm_cnt_t'(789), frm_cnt_t'(779)};
			{FRM_SHORT, 4'd3}:   {kbch_nxt, ts_nxt} = {frm_cnt_t'(879), frm_cnt_t'(869)};
			{FRM_SHORT, 4'd4}:   {kbch_nxt, ts_nxt} = {frm_cnt_t'(1194), frm_cnt_t'(1184)};
			{FRM_SHORT, 4'd5}:   {kbch_nxt, ts_nxt} = {frm_cnt_t'(1329), frm_cnt_t'(1319)};
			{FRM_SHORT, 4'd6}:   {kbch_nxt, ts_nxt} = {frm_cnt_t'(1464), frm_cnt_t'(1454)};
			{FRM_SHORT, 4'd7}:   {kbch_nxt, ts_nxt} = {frm_cnt_t'(1554), frm_cnt_t'(1544)};
			{FRM_SHORT, 4'd8}:   {kbch_nxt, ts_nxt} = {frm_cnt_t'(1644), frm_cnt_t'(1634)};
			{FRM_SHORT, 4'd9}:   {kbch_nxt, ts_nxt} = {frm_cnt_t'(1779), frm_cnt_t'(1769)};
			// invalid rate for this frame size
			default:             {kbch_nxt, ts_nxt} = '0;
		endcase
	end

	//////////////////////////////
	// pl frame length table
	//////////////////////////////

	// symbols per plframe incl. header and pilot blocks
	always_comb begin
		case ({frame_mode, pilot_mode, mod_mode})
			{FRM_NORMAL, 1'b0, MOD_QPSK}:   pl_nxt = frm_cnt_t'(32490);
			{FRM_NORMAL, 1'b0, MOD_8PSK}:   pl_nxt = frm_cnt_t'(21690);
			{FRM_NORMAL, 1'b0, MOD_16APSK}: pl_nxt = frm_cnt_t'(16290);
			{FRM_NORMAL, 1'b0, MOD_32APSK}: pl_nxt = frm_cnt_t'(13050);
			{FRM_NORMAL, 1'b1, MOD_QPSK}:   pl_nxt = frm_cnt_t'(33282);
			{FRM_NORMAL, 1'b1, MOD_8PSK}:   pl_nxt = frm_cnt_t'(22194);
			{FRM_NORMAL, 1'b1, MOD_16APSK}: pl_nxt = frm_cnt_t'(16686);
			{FRM_NORMAL, 1'b1, MOD_32APSK}: pl_nxt = frm_cnt_t'(13338);
			{FRM_SHORT, 1'b0, MOD_QPSK}:    pl_nxt = frm_cnt_t'(8190);
			{FRM_SHORT, 1'b0, MOD_8PSK}:    pl_nxt = frm_cnt_t'(5490);
			{FRM_SHORT, 1'b0, MOD_16APSK}:  pl_nxt = frm_cnt_t'(4140);
			{FRM_SHORT, 1'b0, MOD_32APSK}:  pl_nxt = frm_cnt_t'(3330);
			{FRM_SHORT, 1'b1, MOD_QPSK}:    pl_nxt = frm_cnt_t'(8370);
			{FRM_SHORT, 1'b1, MOD_8PSK}:    pl_nxt = frm_cnt_t'(5598);
			{FRM_SHORT, 1'b1, MOD_16APSK}:  pl_nxt = frm_cnt_t'(4212);
			{FRM_SHORT, 1'b1, MOD_32APSK}:  pl_nxt = frm_cnt_t'(3402);
			default:                        pl_nxt = '0;
		endcase
	end

	// one cycle latency from mode inputs
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			kbch_bytes <= '0;
			ts_bytes   <= '0;
			pl_len     <= '0;
		end else begin
			kbch_bytes <= kbch_nxt;
			ts_bytes   <= ts_nxt;
			pl_len     <= pl_nxt;
		end
	end

	// ts column must sit exactly one bb header below the payload
	a_ts_vs_kbch: assert property (@(posedge sys_clk) disable iff (!glb_rst_n)
		(kbch_bytes != '0) |-> (ts_bytes == kbch_bytes - BB_HDR_BYTES));

endmodule

`default_nettype wire

/* hw/dvbs2_frm_pkg.sv */
`default_nettype none

`include "dvbs2_frm_cfg.svh"

package dvbs2_frm_pkg;

	//////////////////////////////
	// mode encodings
	//////////////////////////////

	// constellation select
	typedef enum logic [1:0] {
		MOD_QPSK   = 2'd0,
		MOD_8PSK   = 2'd1,
		MOD_16APSK = 2'd2,
		MOD_32APSK = 2'd3
	} mod_mode_t;

	// fecframe size
	// normal 64800 bits, short 16200 bits
	typedef enum logic {
		FRM_NORMAL = 1'b0,
		FRM_SHORT  = 1'b1
	} frame_mode_t;

	// ldpc code rate index
	// normal frames 0..10, short frames 0..9
	// anything above is invalid
	typedef logic [3:0] ldpc_rate_t;

	//////////////////////////////
	// count types
	//////////////////////////////

	// byte counts and frame lengths
	typedef logic [`FRM_CNT_W-1:0] frm_cnt_t;

	// position inside a ts packet
	typedef logic [`TS_PHASE_W-1:0] ts_phase_t;

endpackage

`default_nettype wire

/* hw/dvbs2_frm_cfg.svh */
`ifndef DVBS2_FRM_CFG_SVH
`define DVBS2_FRM_CFG_SVH

//////////////////////////////
// frame counts
//////////////////////////////

// width of byte counts and pl frame lengths
`define FRM_CNT_W 16

// frame length used until the first wrap
// table value only taken at a frame boundary
`define FRM_RESET_LEN 9990

//////////////////////////////
// transport stream
//////////////////////////////

// mpeg-ts packet length in bytes
`define TS_PKT_LEN 188

// packet phase counter width, holds 0..187
`define TS_PHASE_W 8

`endif
